/* common/uart_macros.svh */
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// System clock rate in Hz
`define UART_CLOCK_FREQ 1600000

// Serial line rate in bits per second
`define UART_BAUD_RATE 100000

// Clock cycles per serial bit, 16 at the rates above
`define UART_CLKS_PER_BIT (`UART_CLOCK_FREQ / `UART_BAUD_RATE)

// Entries in each echo FIFO
`define ECHO_FIFO_DEPTH 4

`endif

/* common/uart_pkg.sv */
package uart_pkg;

  // One character on the serial line
  typedef logic [7:0] uart_byte_t;

  // Receiver FSM
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  // Transmitter FSM
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

endpackage

/* common/echo_pkg.sv */
package echo_pkg;

  import uart_pkg::*;

  // One received character plus its framing status
  typedef struct packed {
    uart_byte_t data;
    logic       frame_err;
  } rx_beat_t;

  // Echoed in place of a character with a bad stop bit
  localparam uart_byte_t ECHO_SUBST_CHAR = 8'h3F;

endpackage

/* uart/uart_rx.sv */
`include "uart_macros.svh"

module uart_rx
  import uart_pkg::*;
  import echo_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     rx_pin,
  output logic     beat_valid,
  output rx_beat_t beat
);

  localparam int CLKS_PER_BIT = `UART_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

  // Two-stage synchronizer plus one delayed copy for edge detection
  logic rx_meta;
  logic rx_sync;
  logic rx_prev;

  rx_state_e        state;
  logic [CNT_W-1:0] sample_cnt;
  logic [2:0]       bit_idx;
  uart_byte_t       shift_reg;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // Line idles high, so no false edge right out of reset
      rx_meta    <= 1'b1;
      rx_sync    <= 1'b1;
      rx_prev    <= 1'b1;
      state      <= RX_IDLE;
      sample_cnt <= '0;
      bit_idx    <= '0;
      beat_valid <= 1'b0;
    end else begin
      rx_meta    <= rx_pin;
      rx_sync    <= rx_meta;
      rx_prev    <= rx_sync;
      beat_valid <= 1'b0;
      sample_cnt <= sample_cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          // Falling edge opens a frame
          if (rx_prev && !rx_sync) begin
            state      <= RX_START;
            sample_cnt <= '0;
          end
        end
        RX_START: begin
          // Mid-bit check, a high line here means it was only a glitch
          if (sample_cnt == HALF_LAST) begin
            sample_cnt <= '0;
            bit_idx    <= '0;
            state      <= rx_sync ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (sample_cnt == BIT_LAST) begin
            sample_cnt <= '0;
            bit_idx    <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= RX_STOP;
          end
        end
        RX_STOP: begin
          // Beat goes out even with a bad stop bit, flagged as such
          if (sample_cnt == BIT_LAST) begin
            beat_valid <= 1'b1;
            state      <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Payload path, LSB arrives first so shift toward bit 0
  always_ff @(posedge clk) begin
    if (state == RX_DATA && sample_cnt == BIT_LAST) begin
      shift_reg <= {rx_sync, shift_reg[7:1]};
    end
    if (state == RX_STOP && sample_cnt == BIT_LAST) begin
      beat.data      <= shift_reg;
      beat.frame_err <= !rx_sync;
    end
  end

endmodule

/* uart/uart_tx.sv */
`include "uart_macros.svh"

module uart_tx
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       byte_valid,
  output logic       byte_ready,
  input  uart_byte_t tx_byte,
  output logic       tx_pin
);

  localparam int CLKS_PER_BIT = `UART_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

  tx_state_e        state;
  logic [CNT_W-1:0] bit_timer;
  logic [2:0]       bit_idx;
  uart_byte_t       shift_reg;

  // Only take a new byte once the previous stop bit is done
  assign byte_ready = (state == TX_IDLE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= TX_IDLE;
      bit_timer <= '0;
      bit_idx   <= '0;
      tx_pin    <= 1'b1;
    end else begin
      bit_timer <= bit_timer + 1'b1;
      case (state)
        TX_IDLE: begin
          tx_pin <= 1'b1;
          if (byte_valid) begin
            // Start bit goes on the line right after the handshake
            state     <= TX_START;
            bit_timer <= '0;
            tx_pin    <= 1'b0;
          end
        end
        TX_START: begin
          if (bit_timer == BIT_LAST) begin
            state   <= TX_DATA;
            bit_idx <= '0;
            tx_pin  <= shift_reg[0];
          end
        end
        TX_DATA: begin
          if (bit_timer == BIT_LAST) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state  <= TX_STOP;
              tx_pin <= 1'b1;
            end else begin
              // Next bit is the one about to shift into position 0
              tx_pin <= shift_reg[1];
            end
          end
        end
        TX_STOP: begin
          if (bit_timer == BIT_LAST) state <= TX_IDLE;
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Byte capture and LSB-first shifting
  always_ff @(posedge clk) begin
    if (state == TX_IDLE && byte_valid) begin
      shift_reg <= tx_byte;
    end else if (state == TX_DATA && bit_timer == BIT_LAST) begin
      shift_reg <= shift_reg >> 1;
    end
  end

endmodule

/* logic/sync_fifo.sv */
`include "uart_macros.svh"

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = `ECHO_FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

  payload_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  // First-word fall-through, head entry is always on the output
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap explicitly so any depth works
      if (push) wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_data;
  end

endmodule

/* logic/echo_core.sv */
module echo_core
  import uart_pkg::*;
  import echo_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       in_valid,
  output logic       in_ready,
  input  rx_beat_t   in_beat,
  output logic       out_valid,
  input  logic       out_ready,
  output uart_byte_t out_byte
);

  // Echo rule, a framing error wins over the case fold
  function automatic uart_byte_t echo_rule(input rx_beat_t b);
    if (b.frame_err) return ECHO_SUBST_CHAR;
    if (b.data >= 8'h61 && b.data <= 8'h7A) return b.data - 8'h20;
    return b.data;
  endfunction

  // Stage is free when empty or emptying this very cycle
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // Result only loads on a transfer, holds steady while stalled
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_byte <= echo_rule(in_beat);
    end
  end

endmodule

/* logic/uart_echo_top.sv */
`include "uart_macros.svh"

module uart_echo_top
  import uart_pkg::*;
  import echo_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic rx_pin,
  output logic tx_pin
);

  // Receiver to receive FIFO
  logic       rx_beat_valid;
  rx_beat_t   rx_beat;

  // Receive FIFO to echo stage
  logic       core_in_valid;
  logic       core_in_ready;
  rx_beat_t   core_in_beat;

  // Echo stage to transmit FIFO
  logic       core_out_valid;
  logic       core_out_ready;
  uart_byte_t core_out_byte;

  // Transmit FIFO to transmitter
  logic       tx_byte_valid;
  logic       tx_byte_ready;
  uart_byte_t tx_byte;

  uart_rx u_uart_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_pin    (rx_pin),
    .beat_valid(rx_beat_valid),
    .beat      (rx_beat)
  );

  // Receiver cannot stall, so the FIFO ready has no consumer
  sync_fifo #(
    .payload_t(rx_beat_t),
    .DEPTH    (`ECHO_FIFO_DEPTH)
  ) rx_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (rx_beat_valid),
    .in_ready (),
    .in_data  (rx_beat),
    .out_valid(core_in_valid),
    .out_ready(core_in_ready),
    .out_data (core_in_beat)
  );

  echo_core u_echo_core (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (core_in_valid),
    .in_ready (core_in_ready),
    .in_beat  (core_in_beat),
    .out_valid(core_out_valid),
    .out_ready(core_out_ready),
    .out_byte (core_out_byte)
  );

  sync_fifo #(
    .payload_t(uart_byte_t),
    .DEPTH    (`ECHO_FIFO_DEPTH)
  ) tx_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (core_out_valid),
    .in_ready (core_out_ready),
    .in_data  (core_out_byte),
    .out_valid(tx_byte_valid),
    .out_ready(tx_byte_ready),
    .out_data (tx_byte)
  );

  uart_tx u_uart_tx (
    .clk       (clk),
    .rst_n     (rst_n),
    .byte_valid(tx_byte_valid),
    .byte_ready(tx_byte_ready),
    .tx_byte   (tx_byte),
    .tx_pin    (tx_pin)
  );

endmodule

/* verification/uart_terminal_model.sv */
`include "uart_macros.svh"

module uart_terminal_model (
  input  logic clk,
  output logic rx_pin,
  input  logic tx_pin
);

  localparam int CLKS_PER_BIT = `UART_CLKS_PER_BIT;

  // Characters seen on tx_pin in arrival order, consumed through rd_idx
  logic [7:0] rx_queue[$];
  int         rd_idx = 0;

  // Monitor state, bit 0 is the start bit and bit 9 the stop bit
  logic       tx_prev = 1'b1;
  logic       mon_busy = 1'b0;
  int         mon_cnt = 0;
  int         mon_next = 0;
  int         mon_bit = 0;
  logic [7:0] mon_shift = '0;
  int         stop_errs = 0;

  // Independent oversampling receiver on tx_pin
  always @(posedge clk) begin
    tx_prev <= tx_pin;
    if (!mon_busy) begin
      // Falling edge opens a frame
      if (tx_prev && !tx_pin) begin
        mon_busy <= 1'b1;
        mon_cnt  <= 1;
        mon_next <= CLKS_PER_BIT / 2 - 1;
        mon_bit  <= 0;
      end
    end else begin
      mon_cnt <= mon_cnt + 1;
      // Sample points sit in the middle of each bit
      if (mon_cnt == mon_next) begin
        mon_next <= mon_next + CLKS_PER_BIT;
        mon_bit  <= mon_bit + 1;
        if (mon_bit == 0 && tx_pin) begin
          mon_busy <= 1'b0;  // start bit did not hold
        end else if (mon_bit >= 1 && mon_bit <= 8) begin
          mon_shift <= {tx_pin, mon_shift[7:1]};
        end else if (mon_bit == 9) begin
          if (!tx_pin) stop_errs <= stop_errs + 1;
          rx_queue.push_back(mon_shift);
          mon_busy <= 1'b0;
        end
      end
    end
  end

  // Idle line level
  task automatic init_line();
    rx_pin <= 1'b1;
  endtask

  // One 8N1 frame, LSB first, stop bit optionally held low
  task automatic send_byte(input logic [7:0] data, input bit bad_stop);
    logic [9:0] frame;
    frame = {~bad_stop, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      rx_pin <= frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
    // A full idle bit after a low stop so the next start edge is seen
    if (bad_stop) begin
      @(posedge clk);
      rx_pin <= 1'b1;
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  // Low pulse of 4 cycles, well short of half a bit
  task automatic send_glitch();
    @(posedge clk);
    rx_pin <= 1'b0;
    repeat (4) @(posedge clk);
    rx_pin <= 1'b1;
    repeat (CLKS_PER_BIT) @(posedge clk);
  endtask

  // Next received character, ok stays low if none arrives in time
  task automatic get_rx_byte(output logic [7:0] data, output bit ok, input int max_cycles);
    int waited;
    waited = 0;
    while (rx_queue.size() <= rd_idx && waited < max_cycles) begin
      @(negedge clk);
      waited++;
    end
    ok   = (rx_queue.size() > rd_idx);
    data = ok ? rx_queue[rd_idx] : 8'h00;
    if (ok) rd_idx++;
  endtask

  function automatic int pending_count();
    return rx_queue.size() - rd_idx;
  endfunction

  function automatic int stop_error_count();
    return stop_errs;
  endfunction

endmodule

/* verification/uart_echo_properties.sv */
`include "uart_macros.svh"

module uart_echo_properties
  import uart_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic       rx_beat_valid,
  input logic       core_in_valid,
  input logic       core_in_ready,
  input logic       core_out_valid,
  input logic       core_out_ready,
  input uart_byte_t core_out_byte,
  input logic       tx_byte_valid,
  input logic       tx_byte_ready,
  input logic       tx_pin
);

  // FIFO fill levels rebuilt from their push and pop handshakes
  int rx_occupancy;
  int tx_occupancy;

  always @(posedge clk) begin
    if (!rst_n) begin
      rx_occupancy <= 0;
      tx_occupancy <= 0;
    end else begin
      rx_occupancy <= rx_occupancy + int'(rx_beat_valid) - int'(core_in_valid && core_in_ready);
      tx_occupancy <= tx_occupancy + int'(core_out_valid && core_out_ready)
                      - int'(tx_byte_valid && tx_byte_ready);
    end
  end

  // Receiver has no back-pressure, every beat needs a free slot
  rx_fifo_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    rx_beat_valid |-> rx_occupancy < `ECHO_FIFO_DEPTH)
    else $error("receive FIFO pushed while full");

  // Echo stage only takes a beat that was actually stored
  rx_fifo_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    core_in_valid && core_in_ready |-> rx_occupancy > 0)
    else $error("echo stage popped an empty receive FIFO");

  // Echo stage output only lands in a free slot
  tx_fifo_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    core_out_valid && core_out_ready |-> tx_occupancy < `ECHO_FIFO_DEPTH)
    else $error("transmit FIFO pushed while full");

  // Transmitter only takes a byte that was actually stored
  tx_fifo_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    tx_byte_valid && tx_byte_ready |-> tx_occupancy > 0)
    else $error("transmitter popped an empty transmit FIFO");

  // Stalled echo output holds its byte
  echo_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
    core_out_valid && !core_out_ready |=> core_out_valid && $stable(core_out_byte))
    else $error("echo stage output changed while stalled");

  // Idle transmitter keeps the line high
  tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    tx_byte_ready |-> tx_pin)
    else $error("tx_pin low while transmitter idle");

endmodule

bind uart_echo_top uart_echo_properties props (
  .clk           (clk),
  .rst_n         (rst_n),
  .rx_beat_valid (rx_beat_valid),
  .core_in_valid (core_in_valid),
  .core_in_ready (core_in_ready),
  .core_out_valid(core_out_valid),
  .core_out_ready(core_out_ready),
  .core_out_byte (core_out_byte),
  .tx_byte_valid (tx_byte_valid),
  .tx_byte_ready (tx_byte_ready),
  .tx_pin        (tx_pin)
);

/* verification/tb_uart_echo.sv */
`include "uart_macros.svh"

module tb_uart_echo
  import echo_pkg::*;
();

  localparam int CLKS_PER_BIT = `UART_CLKS_PER_BIT;
  localparam int FRAME_CLKS = 10 * CLKS_PER_BIT;
  // Bound on one echo, a few frame times
  localparam int ECHO_TIMEOUT = 4 * FRAME_CLKS;

  // One table row, burst rows go out back to back
  typedef struct {
    logic [7:0] data;
    bit         bad_stop;
    bit         glitch;
    bit         burst;
    logic [7:0] expect_byte;
  } vector_t;

  logic clk;
  logic rst_n;
  logic rx_pin;
  logic tx_pin;

  vector_t    vectors[$];
  logic [7:0] expect_q[$];

  uart_echo_top DUT (
    .clk   (clk),
    .rst_n (rst_n),
    .rx_pin(rx_pin),
    .tx_pin(tx_pin)
  );

  uart_terminal_model term (
    .clk   (clk),
    .rx_pin(rx_pin),
    .tx_pin(tx_pin)
  );

  always #50 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  // Lowercase ASCII folds to uppercase, everything else comes back as is
  function automatic logic [7:0] folded(input logic [7:0] c);
    return (c >= 8'h61 && c <= 8'h7A) ? c - 8'h20 : c;
  endfunction

  // Collect every outstanding echo in order
  task automatic drain_echoes();
    logic [7:0] got;
    logic [7:0] exp;
    bit         ok;
    while (expect_q.size() > 0) begin
      exp = expect_q.pop_front();
      term.get_rx_byte(got, ok, ECHO_TIMEOUT);
      assert (ok) else
        report_failure($sformatf("echo of expected byte 0x%02h never came back", exp));
      assert (got == exp) else
        report_failure($sformatf("error: tx_pin byte expected 0x%02h got 0x%02h", exp, got));
    end
  endtask

  initial begin
    logic [7:0] r;
    void'($urandom(32'h5862_ad95));
    clk   = 1'b0;
    rst_n = 1'b0;
    term.init_line();

    // Pass-through, case fold edges, framing error, glitch
    vectors.push_back('{8'h41, 1'b0, 1'b0, 1'b0, 8'h41});
    vectors.push_back('{8'h5A, 1'b0, 1'b0, 1'b0, 8'h5A});
    vectors.push_back('{8'h60, 1'b0, 1'b0, 1'b0, 8'h60});
    vectors.push_back('{8'h7B, 1'b0, 1'b0, 1'b0, 8'h7B});
    vectors.push_back('{8'h30, 1'b0, 1'b0, 1'b0, 8'h30});
    vectors.push_back('{8'h39, 1'b0, 1'b0, 1'b0, 8'h39});
    vectors.push_back('{8'h21, 1'b0, 1'b0, 1'b0, 8'h21});
    vectors.push_back('{8'h00, 1'b0, 1'b0, 1'b0, 8'h00});
    vectors.push_back('{8'hFF, 1'b0, 1'b0, 1'b0, 8'hFF});
    vectors.push_back('{8'h71, 1'b1, 1'b0, 1'b0, ECHO_SUBST_CHAR});
    vectors.push_back('{8'h6D, 1'b0, 1'b0, 1'b0, 8'h4D});
    vectors.push_back('{8'h78, 1'b0, 1'b1, 1'b0, 8'h58});
    // Whole lowercase alphabet
    for (int c = 'h61; c <= 'h7A; c++) begin
      vectors.push_back('{8'(c), 1'b0, 1'b0, 1'b0, 8'(c - 'h20)});
    end
    // Burst longer than the FIFO depth
    repeat (10) begin
      r = 8'($urandom);
      vectors.push_back('{r, 1'b0, 1'b0, 1'b1, folded(r)});
    end

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // Quiet line after reset
    repeat (FRAME_CLKS) begin
      @(negedge clk);
      assert (tx_pin === 1'b1) else report_failure("tx_pin left idle with no stimulus");
    end
    assert (term.pending_count() == 0) else report_failure("byte received with no stimulus");

    foreach (vectors[i]) begin
      if (!vectors[i].burst) repeat ($urandom_range(0, 3 * CLKS_PER_BIT)) @(posedge clk);
      if (vectors[i].glitch) term.send_glitch();
      term.send_byte(vectors[i].data, vectors[i].bad_stop);
      expect_q.push_back(vectors[i].expect_byte);
      // Burst rows stay queued until the last one is on the line
      if (!vectors[i].burst || i == vectors.size() - 1 || !vectors[i + 1].burst) begin
        drain_echoes();
      end
    end

    // Nothing extra may follow, the glitch in particular
    repeat (2 * FRAME_CLKS) @(posedge clk);
    assert (term.pending_count() == 0) else report_failure("unexpected extra byte on tx_pin");
    assert (term.stop_error_count() == 0) else report_failure("tx_pin frame had a low stop bit");

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+common
common/uart_pkg.sv
common/echo_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
logic/sync_fifo.sv
logic/echo_core.sv
logic/uart_echo_top.sv
verification/uart_terminal_model.sv
verification/uart_echo_properties.sv
verification/tb_uart_echo.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert --timing
TOP       = tb_uart_echo
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --assert --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
